//--- soc_ifc_input_vectors.txt
# kind name, then for bus: write soc_req user addr wdata exp_err exp_rdata
# dmi: en wr_en addr wdata exp_rdata 0 0, pin: cmd_avail debug_locked sel(1=trng_req) exp 0 0 0
bus fuse_uc_done      1 0 0        3000 1        0 0
bus fuse_done_uc_rd   0 1 0        3000 0        0 0
bus uds0_wr           1 1 0        3010 cafe0001 0 0
bus uds0_rd           0 1 0        3010 0        0 cafe0001
bus fuse_soc_done     1 1 0        3000 1        0 0
bus uds0_locked_wr    1 1 0        3010 deadbeef 0 cafe0001
bus uds0_locked_rd    0 1 0        3010 0        0 cafe0001
bus fuse_done_rd      0 1 0        3000 0        0 1
bus trng_user_wr      1 1 0        3020 1234abcd 0 0
bus trng_user_rd      0 1 0        3020 0        0 1234abcd
bus trng_d0_wr        1 1 1234abcd 3030 a5a50001 0 0
bus trng_d0_rd        0 1 0        3030 0        0 a5a50001
bus trng_d0_bad_user  1 1 55       3030 11111111 0 a5a50001
bus trng_d0_uc        1 0 1234abcd 3030 22222222 0 a5a50001
bus trng_d0_kept      0 1 0        3030 0        0 a5a50001
bus trng_lock_wr      1 1 0        3024 1        0 0
bus trng_user_locked  1 1 0        3020 99999999 0 1234abcd
bus trng_user_kept    0 1 0        3020 0        0 1234abcd
bus err_outside       0 1 0        4010 0        1 0
bus err_unmapped      1 1 0        3044 12345678 1 0
bus gen_out_wr        1 1 0        3040 0badf00d 0 0
bus gen_out_rd        0 1 0        3040 0        0 0badf00d
bus intr_en_wr        1 1 0        3054 3        0 0
pin cmd_avail_rise    1 0 0 1 0 0 0
bus intr_w1c          1 1 0        3050 1        0 1
pin cmd_avail_cleared 1 0 0 0 0 0 0
pin debug_lock_toggle 1 1 0 1 0 0 0
bus intr_sts_rd       0 1 0        3050 0        0 2
bus boot_status_wr    1 1 0        3060 b0075a7e 0 0
dmi dmi_go_wr         1 1 61 1 0 0 0
dmi dmi_go_rd         1 0 61 0 1 0 0
pin trng_req_low      1 1 1 0 0 0 0
bus go_trng_wr        1 1 0        3064 3        0 1
pin trng_req_high     1 1 1 1 0 0 0
dmi dmi_boot_rd       1 0 51 0 b0075a7e 0 0
dmi dmi_rdata_hold    0 0 61 0 b0075a7e 0 0

//--- compile.f
+incdir+.
soc_ifc_pkg.sv
soc_ifc_addr_decode.sv
soc_ifc_regs.sv
soc_ifc_rsp.sv
soc_ifc_dmi.sv
soc_ifc_lite_top.sv
tb_clk_gen.sv
soc_ifc_lite_tb.sv

//--- Bender.yml
package:
  name: soc_ifc_lite

export_include_dirs:
  - .

sources:
  - soc_ifc_pkg.sv
  - soc_ifc_addr_decode.sv
  - soc_ifc_regs.sv
  - soc_ifc_rsp.sv
  - soc_ifc_dmi.sv
  - soc_ifc_lite_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - soc_ifc_lite_tb.sv

//--- soc_ifc_lite_tb.sv
`timescale 1ns/10ps
`include "soc_ifc_params.svh"
////////////////////////////////////////
// Testbench for the register window top
// Replays the vector file and checks bus, DMI and pin results
////////////////////////////////////////
module soc_ifc_lite_tb
    import soc_ifc_pkg::*;
();

    localparam int NAME_W  = 8 * 24;
    localparam int MAX_VEC = 64;

    logic                        clk;
    logic                        cptra_noncore_rst_b;
    soc_ifc_req_t                req;
    soc_ifc_rd_t                 rsp;
    logic                        cmd_avail;
    logic                        debug_locked;
    logic                        dmi_en;
    logic                        dmi_wr_en;
    logic [`DMI_ADDR_W-1:0]      dmi_addr;
    logic [`SOC_IFC_DATA_W-1:0]  dmi_wdata;
    logic [`SOC_IFC_DATA_W-1:0]  dmi_rdata;
    logic [`SOC_IFC_DATA_W-1:0]  generic_out;
    logic                        trng_req;
    logic                        intr;

    logic [NAME_W-1:0]  vec_kind [0:MAX_VEC-1];
    logic [NAME_W-1:0]  vec_name [0:MAX_VEC-1];
    logic [31:0]        vec_f    [0:MAX_VEC-1][0:6];
    int                 n_vec;
    int                 cycle;
    int                 cycle_limit;
    integer             seed;

    // Generic output value once all issued writes have landed
    logic [`SOC_IFC_DATA_W-1:0] gen_out_model;

    // Responses still owed by the DUT, with the cycle they are due in
    soc_ifc_rd_t                 exp_q [$];
    logic [NAME_W-1:0]           name_q [$];
    int                          due_q [$];
    logic [`SOC_IFC_DATA_W-1:0]  gen_out_q [$];

    tb_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_b_o (cptra_noncore_rst_b)
    );

    soc_ifc_lite_top dut0 (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_i               (req),
        .rsp_o               (rsp),
        .cmd_avail_i         (cmd_avail),
        .debug_locked_i      (debug_locked),
        .dmi_en_i            (dmi_en),
        .dmi_wr_en_i         (dmi_wr_en),
        .dmi_addr_i          (dmi_addr),
        .dmi_wdata_i         (dmi_wdata),
        .dmi_rdata_o         (dmi_rdata),
        .generic_out_o       (generic_out),
        .trng_req_o          (trng_req),
        .intr_o              (intr)
    );

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_rsp(input logic [NAME_W-1:0] name, input soc_ifc_rd_t exp,
                             input soc_ifc_rd_t act);
        if (act !== exp) begin
            $display("** Error %0s: expected valid=%0b err=%0b rdata=%08h,",
                     name, exp.valid, exp.err, exp.rdata,
                     " actual valid=%0b err=%0b rdata=%08h",
                     act.valid, act.err, act.rdata);
            stop_on_error();
        end
    endtask

    task automatic check_dmi(input logic [NAME_W-1:0] name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("** Error %0s: expected %08h, actual %08h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_pin(input logic [NAME_W-1:0] name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %0s: expected %0b, actual %0b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_generic_out(input logic [NAME_W-1:0] name,
                                     input logic [`SOC_IFC_DATA_W-1:0] exp,
                                     input logic [`SOC_IFC_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("** Error %0s: expected generic_out %08h, actual %08h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic load_vectors();
        integer            fd;
        integer            cnt;
        logic [8*160-1:0]  line;
        logic [NAME_W-1:0] kind;
        logic [NAME_W-1:0] name;
        logic [31:0]       f [0:6];
        n_vec = 0;
        fd = $fopen("soc_ifc_input_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file soc_ifc_input_vectors.txt");
            stop_on_error();
        end
        while (!$feof(fd)) begin
            line = '0;
            if ($fgets(line, fd) != 0) begin
                cnt = $sscanf(line, "%s %s %h %h %h %h %h %h %h", kind, name,
                              f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
                // Header lines start with a lone hash
                if (cnt == 9 && kind != "#" && n_vec < MAX_VEC) begin
                    vec_kind[n_vec] = kind;
                    vec_name[n_vec] = name;
                    for (int k = 0; k < 7; k++) begin
                        vec_f[n_vec][k] = f[k];
                    end
                    n_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic idle_inputs();
        req       = '0;
        dmi_en    = 1'b0;
        dmi_wr_en = 1'b0;
    endtask

    task automatic drive_slot();
        @(posedge clk);
        #1;
        idle_inputs();
    endtask

    // One request strobe, the response is owed two edges later
    task automatic issue_bus(input logic [NAME_W-1:0] name, input logic write, input logic soc,
                             input logic [31:0] user, input logic [15:0] addr,
                             input logic [31:0] wdata, input logic exp_err,
                             input logic [31:0] exp_rdata);
        soc_ifc_rd_t exp;
        exp.valid   = 1'b1;
        exp.rdata   = exp_rdata;
        exp.err     = exp_err;
        req.dv      = 1'b1;
        req.write   = write;
        req.soc_req = soc;
        req.user    = user;
        req.addr    = addr;
        req.wdata   = wdata;
        // The generic output register has no lock
        if (write && addr == (`SOC_IFC_REG_BASE | `SOC_IFC_GEN_OUT_OFS)) begin
            gen_out_model = wdata;
        end
        exp_q.push_back(exp);
        name_q.push_back(name);
        due_q.push_back(cycle + 2);
        gen_out_q.push_back(gen_out_model);
    endtask

    // Random UDS words before the fuse lock, cleared again afterwards
    task automatic check_uds_random();
        logic [31:0] uds [0:1];
        logic [15:0] uds0_addr;
        logic [15:0] uds1_addr;
        uds[0]    = $random(seed);
        uds[1]    = $random(seed);
        uds0_addr = `SOC_IFC_REG_BASE | `SOC_IFC_FUSE_UDS0_OFS;
        uds1_addr = `SOC_IFC_REG_BASE | `SOC_IFC_FUSE_UDS1_OFS;
        drive_slot();
        issue_bus("uds_rand_wr0", 1'b1, 1'b1, 32'h0, uds0_addr, uds[0], 1'b0, 32'h0);
        drive_slot();
        issue_bus("uds_rand_wr1", 1'b1, 1'b1, 32'h0, uds1_addr, uds[1], 1'b0, 32'h0);
        drive_slot();
        issue_bus("uds_rand_rd0", 1'b0, 1'b1, 32'h0, uds0_addr, 32'h0, 1'b0, uds[0]);
        drive_slot();
        issue_bus("uds_rand_rd1", 1'b0, 1'b1, 32'h0, uds1_addr, 32'h0, 1'b0, uds[1]);
        drive_slot();
        issue_bus("uds_rand_clr0", 1'b1, 1'b1, 32'h0, uds0_addr, 32'h0, 1'b0, uds[0]);
        drive_slot();
        issue_bus("uds_rand_clr1", 1'b1, 1'b1, 32'h0, uds1_addr, 32'h0, 1'b0, uds[1]);
    endtask

    task automatic run_vector(input int i);
        logic [NAME_W-1:0] name;
        name = vec_name[i];
        drive_slot();
        if (vec_kind[i] == "bus") begin
            issue_bus(name, vec_f[i][0][0], vec_f[i][1][0], vec_f[i][2], vec_f[i][3][15:0],
                      vec_f[i][4], vec_f[i][5][0], vec_f[i][6]);
        end else if (vec_kind[i] == "dmi") begin
            dmi_en    = vec_f[i][0][0];
            dmi_wr_en = vec_f[i][1][0];
            dmi_addr  = vec_f[i][2][`DMI_ADDR_W-1:0];
            dmi_wdata = vec_f[i][3];
            @(posedge clk);
            #1;
            check_dmi(name, vec_f[i][4], dmi_rdata);
            idle_inputs();
        end else if (vec_kind[i] == "pin") begin
            cmd_avail    = vec_f[i][0][0];
            debug_locked = vec_f[i][1][0];
            @(posedge clk);
            #1;
            check_pin(name, vec_f[i][3][0], vec_f[i][2][0] ? trng_req : intr);
        end else begin
            $display("Vector %0d has an unknown kind %0s", i, vec_kind[i]);
            stop_on_error();
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle_limit != 0 && cycle >= cycle_limit) begin
            $display("The run timed out after %0d cycles without finishing", cycle);
            stop_on_error();
        end
    end

    ////////////////////////////////////////
    // Response monitor
    always @(posedge clk) begin
        #1;
        if (cptra_noncore_rst_b) begin
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                check_rsp(name_q[0], exp_q[0], rsp);
                check_generic_out(name_q[0], gen_out_q[0], generic_out);
                void'(due_q.pop_front());
                void'(exp_q.pop_front());
                void'(name_q.pop_front());
                void'(gen_out_q.pop_front());
            end else if (rsp.valid) begin
                $display("A response came at cycle %0d with no request due", cycle);
                stop_on_error();
            end
        end
    end

    initial begin
        req           = '0;
        cmd_avail     = 1'b0;
        debug_locked  = 1'b0;
        dmi_en        = 1'b0;
        dmi_wr_en     = 1'b0;
        dmi_addr      = '0;
        dmi_wdata     = '0;
        cycle         = 0;
        cycle_limit   = 0;
        gen_out_model = '0;
        seed          = 32'h5769;
        load_vectors();
        cycle_limit = n_vec * 4 + 50;
        wait (cptra_noncore_rst_b === 1'b1);
        check_uds_random();
        for (int i = 0; i < n_vec; i++) begin
            run_vector(i);
        end
        drive_slot();
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (n_vec != 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("No test vectors were read from the vector file");
            stop_on_error();
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps
////////////////////////////////////////
// Testbench clock and reset source
////////////////////////////////////////
module tb_clk_gen (
    output logic clk_o,
    output logic rst_b_o
);

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // Reset held low for three cycles
    initial begin
        rst_b_o = 1'b0;
        repeat (3) @(posedge clk_o);
        #1 rst_b_o = 1'b1;
    end

endmodule

//--- soc_ifc_lite_top.sv
`timescale 1ns/10ps
`include "soc_ifc_params.svh"
////////////////////////////////////////
// SoC interface register window top
// Decode, execute and result stages with the DMI port
////////////////////////////////////////
module soc_ifc_lite_top
    import soc_ifc_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  soc_ifc_req_t                req_i,
    output soc_ifc_rd_t                 rsp_o,
    input  logic                        cmd_avail_i,
    input  logic                        debug_locked_i,
    input  logic                        dmi_en_i,
    input  logic                        dmi_wr_en_i,
    input  logic [`DMI_ADDR_W-1:0]      dmi_addr_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  dmi_wdata_i,
    output logic [`SOC_IFC_DATA_W-1:0]  dmi_rdata_o,
    output logic [`SOC_IFC_DATA_W-1:0]  generic_out_o,
    output logic                        trng_req_o,
    output logic                        intr_o
);

    soc_ifc_access_t            access;
    soc_ifc_rd_t                rd;
    logic [`SOC_IFC_USER_W-1:0] trng_user;
    logic [`SOC_IFC_DATA_W-1:0] boot_status;
    logic [`SOC_IFC_DATA_W-1:0] bootfsm_go;
    logic [`SOC_IFC_DATA_W-1:0] dbg_service;
    logic                       dmi_go_we;
    logic                       dmi_dbg_we;
    logic [`SOC_IFC_DATA_W-1:0] dmi_wdata;

    soc_ifc_addr_decode i_decode (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .req_i               (req_i),
        .trng_user_i         (trng_user),
        .access_o            (access)
    );

    soc_ifc_regs i_regs (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .access_i            (access),
        .cmd_avail_i         (cmd_avail_i),
        .debug_locked_i      (debug_locked_i),
        .dmi_go_we_i         (dmi_go_we),
        .dmi_dbg_we_i        (dmi_dbg_we),
        .dmi_wdata_i         (dmi_wdata),
        .rd_o                (rd),
        .trng_user_o         (trng_user),
        .boot_status_o       (boot_status),
        .bootfsm_go_o        (bootfsm_go),
        .dbg_service_o       (dbg_service),
        .generic_out_o       (generic_out_o),
        .trng_req_o          (trng_req_o),
        .intr_o              (intr_o)
    );

    soc_ifc_rsp i_rsp (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .rd_i                (rd),
        .rsp_o               (rsp_o)
    );

    soc_ifc_dmi i_dmi (
        .clk                 (clk),
        .cptra_noncore_rst_b (cptra_noncore_rst_b),
        .dmi_en_i            (dmi_en_i),
        .dmi_wr_en_i         (dmi_wr_en_i),
        .dmi_addr_i          (dmi_addr_i),
        .dmi_wdata_i         (dmi_wdata_i),
        .boot_status_i       (boot_status),
        .bootfsm_go_i        (bootfsm_go),
        .dbg_service_i       (dbg_service),
        .dmi_rdata_o         (dmi_rdata_o),
        .dmi_go_we_o         (dmi_go_we),
        .dmi_dbg_we_o        (dmi_dbg_we),
        .dmi_wdata_o         (dmi_wdata)
    );

endmodule

//--- soc_ifc_dmi.sv
`timescale 1ns/10ps
`include "soc_ifc_params.svh"
////////////////////////////////////////
// Debug register port
// Write strobes for GO and debug service, captured read mux
////////////////////////////////////////
module soc_ifc_dmi
    import soc_ifc_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  logic                        dmi_en_i,
    input  logic                        dmi_wr_en_i,
    input  logic [`DMI_ADDR_W-1:0]      dmi_addr_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  dmi_wdata_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  boot_status_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  bootfsm_go_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  dbg_service_i,
    output logic [`SOC_IFC_DATA_W-1:0]  dmi_rdata_o,
    output logic                        dmi_go_we_o,
    output logic                        dmi_dbg_we_o,
    output logic [`SOC_IFC_DATA_W-1:0]  dmi_wdata_o
);

    logic                       dmi_wr;
    logic [`SOC_IFC_DATA_W-1:0] rdata_mux;

    assign dmi_wr       = dmi_en_i & dmi_wr_en_i;
    assign dmi_go_we_o  = dmi_wr & (dmi_addr_i == DMI_REG_BOOTFSM_GO);
    assign dmi_dbg_we_o = dmi_wr & (dmi_addr_i == DMI_REG_DBG_SERVICE);
    assign dmi_wdata_o  = dmi_wdata_i;

    // Unknown addresses read as zero
    always_comb begin
        case (dmi_addr_i)
            DMI_REG_BOOT_STATUS: rdata_mux = boot_status_i;
            DMI_REG_BOOTFSM_GO:  rdata_mux = bootfsm_go_i;
            DMI_REG_DBG_SERVICE: rdata_mux = dbg_service_i;
            default:             rdata_mux = '0;
        endcase
    end

    // Holds between enables
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            dmi_rdata_o <= '0;
        end else if (dmi_en_i) begin
            dmi_rdata_o <= rdata_mux;
        end
    end

endmodule

//--- soc_ifc_rsp.sv
`timescale 1ns/10ps
`include "soc_ifc_params.svh"
////////////////////////////////////////
// Result stage, registers the response
////////////////////////////////////////
module soc_ifc_rsp
    import soc_ifc_pkg::*;
(
    input  logic        clk,
    input  logic        cptra_noncore_rst_b,
    input  soc_ifc_rd_t rd_i,
    output soc_ifc_rd_t rsp_o
);

    logic [`SOC_IFC_DATA_W-1:0] rdata_d;

    // An erroring request returns no data
    assign rdata_d = rd_i.err ? '0 : rd_i.rdata;

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            rsp_o <= '0;
        end else begin
            rsp_o.valid <= rd_i.valid;
            rsp_o.rdata <= rdata_d;
            rsp_o.err   <= rd_i.valid & rd_i.err;
        end
    end

    // Back to back responses need back to back requests
    ERR_RSP_EXTRA_VALID: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        rsp_o.valid && $past(rsp_o.valid) |-> $past(rd_i.valid, 1) && $past(rd_i.valid, 2));

endmodule

//--- soc_ifc_regs.sv
`timescale 1ns/10ps
`include "soc_ifc_params.svh"
////////////////////////////////////////
// Execute stage of the register window
// Register storage, locks, interrupt status and read mux
////////////////////////////////////////
module soc_ifc_regs
    import soc_ifc_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  soc_ifc_access_t             access_i,
    input  logic                        cmd_avail_i,
    input  logic                        debug_locked_i,
    input  logic                        dmi_go_we_i,
    input  logic                        dmi_dbg_we_i,
    input  logic [`SOC_IFC_DATA_W-1:0]  dmi_wdata_i,
    output soc_ifc_rd_t                 rd_o,
    output logic [`SOC_IFC_USER_W-1:0]  trng_user_o,
    output logic [`SOC_IFC_DATA_W-1:0]  boot_status_o,
    output logic [`SOC_IFC_DATA_W-1:0]  bootfsm_go_o,
    output logic [`SOC_IFC_DATA_W-1:0]  dbg_service_o,
    output logic [`SOC_IFC_DATA_W-1:0]  generic_out_o,
    output logic                        trng_req_o,
    output logic                        intr_o
);

    logic                             fuse_done_q;
    logic [1:0][`SOC_IFC_DATA_W-1:0]  uds_q;
    logic [`SOC_IFC_USER_W-1:0]       trng_user_q;
    logic                             trng_lock_q;
    logic [1:0][`SOC_IFC_DATA_W-1:0]  trng_data_q;
    logic [`SOC_IFC_DATA_W-1:0]       gen_out_q;
    logic [1:0]                       intr_sts_q;
    logic [1:0]                       intr_en_q;
    logic [`SOC_IFC_DATA_W-1:0]       boot_status_q;
    logic [1:0]                       go_q;
    logic [`SOC_IFC_DATA_W-1:0]       dbg_service_q;

    logic                             wr;
    logic                             trng_wr_ok;
    logic [`SOC_IFC_DATA_W-1:0]       wdata;
    logic                             cmd_avail_d;
    logic                             debug_locked_d;
    logic [1:0]                       intr_set;
    logic [1:0]                       intr_clr;
    logic [`SOC_IFC_DATA_W-1:0]       rdata;

    assign wr         = access_i.valid & access_i.write & ~access_i.err;
    assign wdata      = access_i.wdata;
    // TRNG data only from the SoC's valid user
    assign trng_wr_ok = access_i.soc_req & access_i.user_match;

    // Bit 0 command available on a rising edge, bit 1 any debug lock change
    assign intr_set[0] = cmd_avail_i & ~cmd_avail_d;
    assign intr_set[1] = debug_locked_i ^ debug_locked_d;
    assign intr_clr    = (wr && access_i.reg_id == REG_INTR_STS) ? wdata[1:0] : 2'b00;

    ////////////////////////////////////////
    // Storage
    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            fuse_done_q    <= 1'b0;
            uds_q          <= '0;
            trng_user_q    <= '0;
            trng_lock_q    <= 1'b0;
            trng_data_q    <= '0;
            gen_out_q      <= '0;
            intr_sts_q     <= '0;
            intr_en_q      <= '0;
            boot_status_q  <= '0;
            go_q           <= '0;
            dbg_service_q  <= '0;
            cmd_avail_d    <= 1'b0;
            debug_locked_d <= 1'b0;
        end else begin
            if (wr) begin
                case (access_i.reg_id)
                    REG_FUSE_WR_DONE: if (access_i.soc_req) fuse_done_q <= fuse_done_q | wdata[0];
                    REG_FUSE_UDS0:    if (!fuse_done_q) uds_q[0] <= wdata;
                    REG_FUSE_UDS1:    if (!fuse_done_q) uds_q[1] <= wdata;
                    REG_TRNG_USER:    if (!trng_lock_q) trng_user_q <= wdata;
                    REG_TRNG_LOCK:    trng_lock_q <= trng_lock_q | wdata[0];
                    REG_TRNG_DATA0:   if (trng_wr_ok) trng_data_q[0] <= wdata;
                    REG_TRNG_DATA1:   if (trng_wr_ok) trng_data_q[1] <= wdata;
                    REG_GEN_OUT:      gen_out_q <= wdata;
                    REG_INTR_EN:      intr_en_q <= wdata[1:0];
                    REG_BOOT_STATUS:  boot_status_q <= wdata;
                    REG_BOOTFSM_GO:   go_q <= wdata[1:0];
                    REG_DBG_SERVICE:  dbg_service_q <= wdata;
                    default: ;
                endcase
            end
            // DMI wins over a bus write in the same cycle
            if (dmi_go_we_i) begin
                go_q[0] <= dmi_wdata_i[0];
            end
            if (dmi_dbg_we_i) begin
                dbg_service_q <= dmi_wdata_i;
            end
            // Set pulse beats the W1C
            intr_sts_q     <= (intr_sts_q & ~intr_clr) | intr_set;
            cmd_avail_d    <= cmd_avail_i;
            debug_locked_d <= debug_locked_i;
        end
    end

    ////////////////////////////////////////
    // Read mux, value before this edge's write
    always_comb begin
        rdata = '0;
        case (access_i.reg_id)
            REG_FUSE_WR_DONE: rdata[0]    = fuse_done_q;
            REG_FUSE_UDS0:    rdata       = uds_q[0];
            REG_FUSE_UDS1:    rdata       = uds_q[1];
            REG_TRNG_USER:    rdata       = trng_user_q;
            REG_TRNG_LOCK:    rdata[0]    = trng_lock_q;
            REG_TRNG_DATA0:   rdata       = trng_data_q[0];
            REG_TRNG_DATA1:   rdata       = trng_data_q[1];
            REG_GEN_OUT:      rdata       = gen_out_q;
            REG_INTR_STS:     rdata[1:0]  = intr_sts_q;
            REG_INTR_EN:      rdata[1:0]  = intr_en_q;
            REG_BOOT_STATUS:  rdata       = boot_status_q;
            REG_BOOTFSM_GO:   rdata[1:0]  = go_q;
            REG_DBG_SERVICE:  rdata       = dbg_service_q;
            default: ;
        endcase
    end

    assign rd_o = '{valid: access_i.valid, rdata: rdata, err: access_i.err};

    always_comb begin
        bootfsm_go_o      = '0;
        bootfsm_go_o[1:0] = go_q;
    end

    assign trng_user_o   = trng_user_q;
    assign boot_status_o = boot_status_q;
    assign dbg_service_o = dbg_service_q;
    assign generic_out_o = gen_out_q;
    assign trng_req_o    = go_q[1];
    assign intr_o        = |(intr_sts_q & intr_en_q);

    // Locks only clear through reset
    ERR_LOCK_FELL: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        !$fell(fuse_done_q) && !$fell(trng_lock_q));

endmodule

//--- soc_ifc_addr_decode.sv
`timescale 1ns/10ps
`include "soc_ifc_params.svh"
////////////////////////////////////////
// Decode stage of the register window
// Qualifies the window, maps the offset and registers the access
////////////////////////////////////////
module soc_ifc_addr_decode
    import soc_ifc_pkg::*;
(
    input  logic                        clk,
    input  logic                        cptra_noncore_rst_b,
    input  soc_ifc_req_t                req_i,
    input  logic [`SOC_IFC_USER_W-1:0]  trng_user_i,
    output soc_ifc_access_t             access_o
);

    localparam logic [`SOC_IFC_ADDR_W-1:0] REG_BASE = `SOC_IFC_REG_BASE;

    logic            win_hit;
    soc_ifc_reg_e    ofs_id;
    soc_ifc_reg_e    reg_id;
    soc_ifc_access_t access_d;

    // Only the upper address bits select the window
    assign win_hit = req_i.addr[`SOC_IFC_ADDR_W-1:`SOC_IFC_REG_ADDR_W] ==
                     REG_BASE[`SOC_IFC_ADDR_W-1:`SOC_IFC_REG_ADDR_W];

    always_comb begin
        case (req_i.addr[`SOC_IFC_REG_ADDR_W-1:0])
            `SOC_IFC_FUSE_WR_DONE_OFS: ofs_id = REG_FUSE_WR_DONE;
            `SOC_IFC_FUSE_UDS0_OFS:    ofs_id = REG_FUSE_UDS0;
            `SOC_IFC_FUSE_UDS1_OFS:    ofs_id = REG_FUSE_UDS1;
            `SOC_IFC_TRNG_USER_OFS:    ofs_id = REG_TRNG_USER;
            `SOC_IFC_TRNG_LOCK_OFS:    ofs_id = REG_TRNG_LOCK;
            `SOC_IFC_TRNG_DATA0_OFS:   ofs_id = REG_TRNG_DATA0;
            `SOC_IFC_TRNG_DATA1_OFS:   ofs_id = REG_TRNG_DATA1;
            `SOC_IFC_GEN_OUT_OFS:      ofs_id = REG_GEN_OUT;
            `SOC_IFC_INTR_STS_OFS:     ofs_id = REG_INTR_STS;
            `SOC_IFC_INTR_EN_OFS:      ofs_id = REG_INTR_EN;
            `SOC_IFC_BOOT_STATUS_OFS:  ofs_id = REG_BOOT_STATUS;
            `SOC_IFC_BOOTFSM_GO_OFS:   ofs_id = REG_BOOTFSM_GO;
            `SOC_IFC_DBG_SERVICE_OFS:  ofs_id = REG_DBG_SERVICE;
            default:                   ofs_id = REG_NONE;
        endcase
    end

    // A miss aliases to nothing
    assign reg_id = win_hit ? ofs_id : REG_NONE;

    always_comb begin
        access_d.valid      = req_i.dv;
        access_d.write      = req_i.write;
        access_d.soc_req    = req_i.soc_req;
        access_d.user_match = req_i.user == trng_user_i;
        access_d.reg_id     = reg_id;
        access_d.wdata      = req_i.wdata;
        access_d.err        = req_i.dv & (reg_id == REG_NONE);
    end

    always_ff @(posedge clk or negedge cptra_noncore_rst_b) begin
        if (!cptra_noncore_rst_b) begin
            access_o <= '0;
        end else begin
            access_o <= access_d;
        end
    end

    // A request to a listed offset inside the window never reaches execute flagged as an error
    ERR_DECODE_FALSE_ERR: assert property (@(posedge clk) disable iff (!cptra_noncore_rst_b)
        req_i.dv &&
        (req_i.addr[`SOC_IFC_ADDR_W-1:`SOC_IFC_REG_ADDR_W] ==
         REG_BASE[`SOC_IFC_ADDR_W-1:`SOC_IFC_REG_ADDR_W]) &&
        (req_i.addr[`SOC_IFC_REG_ADDR_W-1:0] inside {
            `SOC_IFC_FUSE_WR_DONE_OFS, `SOC_IFC_FUSE_UDS0_OFS, `SOC_IFC_FUSE_UDS1_OFS,
            `SOC_IFC_TRNG_USER_OFS, `SOC_IFC_TRNG_LOCK_OFS, `SOC_IFC_TRNG_DATA0_OFS,
            `SOC_IFC_TRNG_DATA1_OFS, `SOC_IFC_GEN_OUT_OFS, `SOC_IFC_INTR_STS_OFS,
            `SOC_IFC_INTR_EN_OFS, `SOC_IFC_BOOT_STATUS_OFS, `SOC_IFC_BOOTFSM_GO_OFS,
            `SOC_IFC_DBG_SERVICE_OFS})
        |=> access_o.valid && !access_o.err && (access_o.reg_id != REG_NONE));

endmodule

//--- soc_ifc_pkg.sv
////////////////////////////////////////
// Types shared by the register window stages
////////////////////////////////////////
`include "soc_ifc_params.svh"

package soc_ifc_pkg;

    // Request as it arrives from the requester
    typedef struct packed {
        logic                        dv;
        logic                        write;
        logic                        soc_req;
        logic [`SOC_IFC_USER_W-1:0]  user;
        logic [`SOC_IFC_ADDR_W-1:0]  addr;
        logic [`SOC_IFC_DATA_W-1:0]  wdata;
    } soc_ifc_req_t;

    // One id per mapped register, REG_NONE for a hole or a miss
    typedef enum logic [3:0] {
        REG_NONE,
        REG_FUSE_WR_DONE,
        REG_FUSE_UDS0,
        REG_FUSE_UDS1,
        REG_TRNG_USER,
        REG_TRNG_LOCK,
        REG_TRNG_DATA0,
        REG_TRNG_DATA1,
        REG_GEN_OUT,
        REG_INTR_STS,
        REG_INTR_EN,
        REG_BOOT_STATUS,
        REG_BOOTFSM_GO,
        REG_DBG_SERVICE
    } soc_ifc_reg_e;

    // Decoded access handed to the execute stage
    typedef struct packed {
        logic                        valid;
        logic                        write;
        logic                        soc_req;
        logic                        user_match;
        soc_ifc_reg_e                reg_id;
        logic [`SOC_IFC_DATA_W-1:0]  wdata;
        logic                        err;
    } soc_ifc_access_t;

    // Read result, also the response format
    typedef struct packed {
        logic                        valid;
        logic [`SOC_IFC_DATA_W-1:0]  rdata;
        logic                        err;
    } soc_ifc_rd_t;

    typedef enum logic [`DMI_ADDR_W-1:0] {
        DMI_REG_BOOT_STATUS = `DMI_BOOT_STATUS_ADDR,
        DMI_REG_BOOTFSM_GO  = `DMI_BOOTFSM_GO_ADDR,
        DMI_REG_DBG_SERVICE = `DMI_DBG_SERVICE_ADDR
    } dmi_reg_e;

endpackage

//--- soc_ifc_params.svh
////////////////////////////////////////
// Widths, register offsets and DMI addresses
// for the SoC interface register window
////////////////////////////////////////
`ifndef SOC_IFC_PARAMS_SVH
`define SOC_IFC_PARAMS_SVH

// Bus widths
`define SOC_IFC_DATA_W      32
`define SOC_IFC_ADDR_W      16
`define SOC_IFC_USER_W      32
`define SOC_IFC_REG_ADDR_W  8
`define SOC_IFC_REG_BASE    16'h3000

// Byte offsets inside the window
`define SOC_IFC_FUSE_WR_DONE_OFS  8'h00
`define SOC_IFC_FUSE_UDS0_OFS     8'h10
`define SOC_IFC_FUSE_UDS1_OFS     8'h14
`define SOC_IFC_TRNG_USER_OFS     8'h20
`define SOC_IFC_TRNG_LOCK_OFS     8'h24
`define SOC_IFC_TRNG_DATA0_OFS    8'h30
`define SOC_IFC_TRNG_DATA1_OFS    8'h34
`define SOC_IFC_GEN_OUT_OFS       8'h40
`define SOC_IFC_INTR_STS_OFS      8'h50
`define SOC_IFC_INTR_EN_OFS       8'h54
`define SOC_IFC_BOOT_STATUS_OFS   8'h60
`define SOC_IFC_BOOTFSM_GO_OFS    8'h64
`define SOC_IFC_DBG_SERVICE_OFS   8'h68

// Debug port
`define DMI_ADDR_W              7
`define DMI_BOOT_STATUS_ADDR    7'h51
`define DMI_BOOTFSM_GO_ADDR     7'h61
`define DMI_DBG_SERVICE_ADDR    7'h62

`endif
